/* verilog.f */
+incdir+hdl
+incdir+tests
hdl/rv_pkg.sv
hdl/pipe_pkg.sv
hdl/dmem_if.sv
hdl/data_ram.sv
hdl/load_align.sv
hdl/store_align.sv
hdl/mem_stage.sv
hdl/mem_subsys_top.sv
tests/tb_top.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --top-module tb_top -f verilog.f -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Verification passed" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation did not pass"; exit 1; }

/* tests/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errs = 0;
int other_errs = 0;

task automatic check_xlen(input string name, input rv_pkg::xlen_t got, input rv_pkg::xlen_t exp);
	if (got !== exp) begin
		value_errs++;
		$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
	end
endtask

task automatic check_rd(input string name, input rv_pkg::reg_idx_t got,
		input rv_pkg::reg_idx_t exp);
	if (got !== exp) begin
		value_errs++;
		$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
	end
endtask

task automatic check_inst(input string name, input rv_pkg::inst_t got, input rv_pkg::inst_t exp);
	if (got !== exp) begin
		value_errs++;
		$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		value_errs++;
		$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
	end
endtask

task automatic note_failure(input string what);
	other_errs++;
	$display("at %0t: %s", $time, what);
endtask

`endif

/* tests/tb_top.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_top;

	localparam int N_RECORDS  = 400;
	localparam int N_IMAGE    = 16;  // words preloaded by sd
	localparam int PAT_LEN    = 1024;
	localparam int TIMEOUT_NS = (N_RECORDS + N_IMAGE) * 20 * 10 + 2000;

	logic clk = 1'b0;
	logic reset;
	logic in_valid, in_ready, out_valid, out_ready;
	rv_pkg::addr_t in_pc, out_pc;
	rv_pkg::inst_t in_inst, out_inst;
	rv_pkg::xlen_t in_alu_result, in_rs2_data, out_wb_data, fwd_wb_data;
	rv_pkg::reg_idx_t in_rd, out_rd, fwd_rd;
	logic in_reg_we, in_mem_we, in_wb_sel, out_reg_we, fwd_reg_we;

	logic [7:0] model_mem [`MEM_DEPTH*8];  // byte image of data memory
	pipe_pkg::mem_wb_t exp_q [$];
	pipe_pkg::mem_wb_t held_rec;
	logic held_valid = 1'b0;
	logic seen_accept = 1'b0;
	logic ready_pat [PAT_LEN];
	int in_count = 0;
	int out_count = 0;

	`include "tb_checks.svh"

	always #5 clk = ~clk;

	mem_subsys_top mem_subsys_top_i (.*);

	function automatic int access_bytes(input rv_pkg::funct3_t f3);
		case (f3)
			rv_pkg::F3_B, rv_pkg::F3_BU: return 1;
			rv_pkg::F3_H, rv_pkg::F3_HU: return 2;
			rv_pkg::F3_W, rv_pkg::F3_WU: return 4;
			rv_pkg::F3_D: return 8;
			default: return 0;
		endcase
	endfunction

	// write-back value the stage should produce for a record
	function automatic rv_pkg::xlen_t expected_wb(input rv_pkg::inst_t inst,
			input rv_pkg::xlen_t alu, input logic wb_sel);
		rv_pkg::xlen_t off;
		rv_pkg::xlen_t v;
		logic [`MEM_IDX_W+2:0] bidx;
		int n;
		if (!wb_sel)
			return alu;
		if (inst[6:0] != rv_pkg::OP_LOAD)
			return '0;
		n = access_bytes(inst[14:12]);
		off = alu - `MEM_BASE;
		bidx = off[`MEM_IDX_W+2:0];
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = v | ({56'h0, model_mem[bidx]} << (8 * k));  // little endian
			bidx++;
		end
		if (inst[14:12] inside {rv_pkg::F3_B, rv_pkg::F3_H, rv_pkg::F3_W}) begin
			if (((v >> (8 * n - 1)) & 64'h1) != 64'h0)
				v = v | (~64'h0 << (8 * n));  // sign fill
		end
		return v;
	endfunction

	task automatic apply_store(input rv_pkg::funct3_t f3, input rv_pkg::xlen_t addr,
			input rv_pkg::xlen_t data);
		rv_pkg::xlen_t off;
		logic [`MEM_IDX_W+2:0] bidx;
		int n;
		n = (f3 inside {rv_pkg::F3_B, rv_pkg::F3_H, rv_pkg::F3_W, rv_pkg::F3_D}) ?
			access_bytes(f3) : 0;
		off = addr - `MEM_BASE;
		bidx = off[`MEM_IDX_W+2:0];
		for (int k = 0; k < n; k++) begin
			model_mem[bidx] = 8'(data >> (8 * k));
			bidx++;
		end
	endtask

	// monitor samples mid-cycle where inputs and outputs are settled
	always @(negedge clk) begin
		pipe_pkg::mem_wb_t exp_rec;
		rv_pkg::xlen_t wb_exp;
		if (!reset) begin
			if (!seen_accept && out_valid)
				note_failure("out_valid went high before any input was accepted");
			if (held_valid) begin
				check_xlen("out_pc (stalled)", out_pc, held_rec.pc);
				check_inst("out_inst (stalled)", out_inst, held_rec.inst);
				check_rd("out_rd (stalled)", out_rd, held_rec.rd);
				check_flag("out_reg_we (stalled)", out_reg_we, held_rec.reg_we);
				check_xlen("out_wb_data (stalled)", out_wb_data, held_rec.wb_data);
			end
			held_valid = out_valid && !out_ready;
			held_rec = '{out_pc, out_inst, out_rd, out_reg_we, out_wb_data};
			if (held_valid && in_ready)
				note_failure("in_ready is high while the output is stalled");
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					note_failure("output transfer with no record expected");
				end else begin
					exp_rec = exp_q.pop_front();
					check_xlen("out_pc", out_pc, exp_rec.pc);
					check_inst("out_inst", out_inst, exp_rec.inst);
					check_rd("out_rd", out_rd, exp_rec.rd);
					check_flag("out_reg_we", out_reg_we, exp_rec.reg_we);
					check_xlen("out_wb_data", out_wb_data, exp_rec.wb_data);
				end
				out_count++;
			end
			if (in_valid) begin
				wb_exp = expected_wb(in_inst, in_alu_result, in_wb_sel);
				check_xlen("fwd_wb_data", fwd_wb_data, wb_exp);
				check_rd("fwd_rd", fwd_rd, in_rd);
				check_flag("fwd_reg_we", fwd_reg_we, in_reg_we);
				if (in_ready) begin
					exp_rec = '{in_pc, in_inst, in_rd, in_reg_we, wb_exp};
					exp_q.push_back(exp_rec);
					if (in_mem_we)
						apply_store(in_inst[14:12], in_alu_result, in_rs2_data);
					seen_accept = 1'b1;
					in_count++;
				end
			end
		end
	end

	task automatic send(input pipe_pkg::ex_mem_t rec);
		in_pc = rec.pc;
		in_inst = rec.inst;
		in_alu_result = rec.alu_result;
		in_rs2_data = rec.rs2_data;
		in_rd = rec.rd;
		in_reg_we = rec.reg_we;
		in_mem_we = rec.mem_we;
		in_wb_sel = rec.wb_sel;
		in_valid = 1'b1;
		@(negedge clk);
		while (!in_ready)
			@(negedge clk);
		@(posedge clk);
		#1;
	endtask

	function automatic pipe_pkg::ex_mem_t random_record();
		pipe_pkg::ex_mem_t rec;
		rv_pkg::funct3_t f3;
		logic [6:0] op;
		int kind;
		int n;
		int offset;
		kind = int'($urandom % 8);
		rec.pc = {$urandom, $urandom};
		rec.rd = 5'($urandom);
		rec.rs2_data = {$urandom, $urandom};
		rec.alu_result = {$urandom, $urandom};
		rec.mem_we = 1'b0;
		if (kind < 5) begin
			f3 = (kind < 3) ? 3'($urandom % 7) : 3'($urandom % 4);  // all loads, all stores
			op = (kind < 3) ? rv_pkg::OP_LOAD : rv_pkg::OP_STORE;
			n = access_bytes(f3);
			offset = int'($urandom % (8 / n)) * n;  // naturally aligned
			rec.alu_result = `MEM_BASE + 64'(int'($urandom % N_IMAGE) * 8 + offset);
			rec.mem_we = (kind >= 3);
			rec.reg_we = (kind < 3);
			rec.wb_sel = (kind < 3);
		end else begin
			f3 = 3'($urandom);
			case ($urandom % 4)
				0: op = rv_pkg::OP_IMM;
				1: op = rv_pkg::OP_REG;
				2: op = rv_pkg::OP_LUI;
				default: op = rv_pkg::OP_JAL;
			endcase
			rec.reg_we = 1'($urandom);
			rec.wb_sel = ($urandom % 8) == 0;  // memory select without a load
		end
		rec.inst = {17'($urandom), f3, 5'($urandom), op};
		return rec;
	endfunction

	initial begin
		int cyc;
		cyc = 0;
		out_ready = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			out_ready = reset ? 1'b1 : ready_pat[cyc % PAT_LEN];  // per clock cycle
			cyc++;
		end
	end

	initial begin
		pipe_pkg::ex_mem_t rec;
		void'($urandom(28896));
		for (int i = 0; i < PAT_LEN; i++)
			ready_pat[i] = ($urandom % 4) != 0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_pc = '0;
		in_inst = '0;
		in_alu_result = '0;
		in_rs2_data = '0;
		in_rd = '0;
		in_reg_we = 1'b0;
		in_mem_we = 1'b0;
		in_wb_sel = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (3) @(posedge clk);  // out_valid must stay low while idle
		#1;
		for (int w = 0; w < N_IMAGE; w++) begin
			rec = '0;
			rec.inst = {17'h0, rv_pkg::F3_D, 5'h0, rv_pkg::OP_STORE};
			rec.alu_result = `MEM_BASE + 64'(w * 8);
			rec.rs2_data = 64'h5a3c_0000_0000_0000 ^ ({56'h0, 8'(w)} * 64'h0001_0203_0405_0607);
			rec.mem_we = 1'b1;
			send(rec);
		end
		for (int i = 0; i < N_RECORDS; i++) begin
			if ($urandom % 4 == 0) begin
				in_valid = 1'b0;
				repeat (1 + $urandom % 3) begin
					@(posedge clk);
					#1;
				end
			end
			send(random_record());
		end
		in_valid = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (2) @(posedge clk);
		if (in_count != out_count)
			note_failure("number of accepted inputs differs from number of outputs");
		$display("tb_top: %0d value errors, %0d other errors, %0d records",
			value_errs, other_errs, out_count);
		if (value_errs + other_errs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not finish in %0d ns", TIMEOUT_NS);
		$display("Verification failed");
		$finish;
	end

endmodule

/* hdl/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
	input  logic             clk,
	input  logic             reset,
	input  logic             in_valid,
	output logic             in_ready,
	input  rv_pkg::addr_t    in_pc,
	input  rv_pkg::inst_t    in_inst,
	input  rv_pkg::xlen_t    in_alu_result,
	input  rv_pkg::xlen_t    in_rs2_data,
	input  rv_pkg::reg_idx_t in_rd,
	input  logic             in_reg_we,
	input  logic             in_mem_we,
	input  logic             in_wb_sel,
	output logic             out_valid,
	input  logic             out_ready,
	output rv_pkg::addr_t    out_pc,
	output rv_pkg::inst_t    out_inst,
	output rv_pkg::reg_idx_t out_rd,
	output logic             out_reg_we,
	output rv_pkg::xlen_t    out_wb_data,
	output rv_pkg::reg_idx_t fwd_rd,
	output logic             fwd_reg_we,
	output rv_pkg::xlen_t    fwd_wb_data
);

	pipe_pkg::ex_mem_t in_rec;
	pipe_pkg::mem_wb_t out_rec;
	pipe_pkg::fwd_t    fwd_rec;

	dmem_if mem_bus ();

	assign in_rec.pc         = in_pc;
	assign in_rec.inst       = in_inst;
	assign in_rec.alu_result = in_alu_result;
	assign in_rec.rs2_data   = in_rs2_data;
	assign in_rec.rd         = in_rd;
	assign in_rec.reg_we     = in_reg_we;
	assign in_rec.mem_we     = in_mem_we;
	assign in_rec.wb_sel     = in_wb_sel;

	mem_stage mem_stage_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in        (in_rec),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out       (out_rec),
		.fwd       (fwd_rec),
		.mem       (mem_bus.master)
	);

	data_ram data_ram_i (
		.clk (clk),
		.mem (mem_bus.slave)
	);

	assign out_pc      = out_rec.pc;
	assign out_inst    = out_rec.inst;
	assign out_rd      = out_rec.rd;
	assign out_reg_we  = out_rec.reg_we;
	assign out_wb_data = out_rec.wb_data;

	assign fwd_rd      = fwd_rec.rd;
	assign fwd_reg_we  = fwd_rec.reg_we;
	assign fwd_wb_data = fwd_rec.wb_data;

endmodule

/* hdl/mem_stage.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  pipe_pkg::ex_mem_t in,
	output logic              in_ready,
	output logic              out_valid,
	input  logic              out_ready,
	output pipe_pkg::mem_wb_t out,
	output pipe_pkg::fwd_t    fwd,
	dmem_if.master            mem
);

	rv_pkg::addr_t   mem_off;
	rv_pkg::funct3_t funct3;
	rv_pkg::xlen_t   load_data;
	rv_pkg::xlen_t   wb_data;
	logic            is_load;
	logic            accept;

	assign funct3  = in.inst[14:12];
	assign is_load = in.wb_sel && (in.inst[6:0] == rv_pkg::OP_LOAD);

	// register empty or draining
	assign in_ready = !out_valid || out_ready;
	assign accept   = in_valid && in_ready;

	assign mem_off = in.alu_result - `MEM_BASE;

	assign mem.en  = is_load;
	assign mem.we  = accept && in.mem_we;  // once per store
	assign mem.idx = mem_off[`MEM_IDX_W+2:3];

	load_align load_align_i (
		.rdata  (mem.rdata),
		.funct3 (funct3),
		.offset (in.alu_result[2:0]),
		.data   (load_data)
	);

	store_align store_align_i (
		.rs2_data (in.rs2_data),
		.funct3   (funct3),
		.offset   (in.alu_result[2:0]),
		.wdata    (mem.wdata),
		.wmask    (mem.wmask)
	);

	always_comb begin
		if (in.wb_sel) begin
			wb_data = is_load ? load_data : '0;
		end else begin
			wb_data = in.alu_result;
		end
	end

	// forwarding toward decode
	assign fwd.rd      = in.rd;
	assign fwd.reg_we  = in.reg_we;
	assign fwd.wb_data = wb_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out.pc      <= in.pc;
			out.inst    <= in.inst;
			out.rd      <= in.rd;
			out.reg_we  <= in.reg_we;
			out.wb_data <= wb_data;
		end
	end

endmodule

/* hdl/store_align.sv */
`timescale 1ns/1ps

module store_align (
	input  rv_pkg::xlen_t        rs2_data,
	input  rv_pkg::funct3_t      funct3,
	input  logic [2:0]           offset,
	output rv_pkg::xlen_t        wdata,
	output pipe_pkg::byte_mask_t wmask
);

	always_comb begin
		case (funct3)
			rv_pkg::F3_B: begin
				wdata = {8{rs2_data[7:0]}};
				wmask = 8'b0000_0001 << offset;
			end
			rv_pkg::F3_H: begin
				wdata = {4{rs2_data[15:0]}};
				wmask = 8'b0000_0011 << {offset[2:1], 1'b0};
			end
			rv_pkg::F3_W: begin
				wdata = {2{rs2_data[31:0]}};
				wmask = 8'b0000_1111 << {offset[2], 2'b00};
			end
			rv_pkg::F3_D: begin
				wdata = rs2_data;
				wmask = 8'b1111_1111;
			end
			default: begin
				wdata = rs2_data;
				wmask = '0;  // no lane written
			end
		endcase
	end

endmodule

/* hdl/load_align.sv */
`timescale 1ns/1ps

module load_align (
	input  rv_pkg::xlen_t   rdata,
	input  rv_pkg::funct3_t funct3,
	input  logic [2:0]      offset,
	output rv_pkg::xlen_t   data
);

	rv_pkg::xlen_t byte_sh;
	rv_pkg::xlen_t half_sh;
	rv_pkg::xlen_t word_sh;

	// bring the addressed unit down to lane 0
	assign byte_sh = rdata >> {offset, 3'b000};
	assign half_sh = rdata >> {offset[2:1], 4'b0000};  // half aligned
	assign word_sh = rdata >> {offset[2], 5'b00000};   // word aligned

	always_comb begin
		case (funct3)
			rv_pkg::F3_B: begin
				data = {{56{byte_sh[7]}}, byte_sh[7:0]};
			end
			rv_pkg::F3_H: begin
				data = {{48{half_sh[15]}}, half_sh[15:0]};
			end
			rv_pkg::F3_W: begin
				data = {{32{word_sh[31]}}, word_sh[31:0]};
			end
			rv_pkg::F3_D: begin
				data = rdata;  // ld
			end
			rv_pkg::F3_BU: begin
				data = {56'h0, byte_sh[7:0]};
			end
			rv_pkg::F3_HU: begin
				data = {48'h0, half_sh[15:0]};
			end
			rv_pkg::F3_WU: begin
				data = {32'h0, word_sh[31:0]};
			end
			default: begin
				data = '0;
			end
		endcase
	end

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module data_ram (
	input logic   clk,
	dmem_if.slave mem
);

	rv_pkg::xlen_t ram [`MEM_DEPTH];

	// asynchronous read
	assign mem.rdata = mem.en ? ram[mem.idx] : '0;

	always_ff @(posedge clk) begin
		if (mem.we) begin
			for (int i = 0; i < `MEM_XLEN / 8; i++) begin
				if (mem.wmask[i]) begin
					ram[mem.idx][i*8 +: 8] <= mem.wdata[i*8 +: 8];  // masked lane
				end
			end
		end
	end

endmodule

/* hdl/dmem_if.sv */
`timescale 1ns/1ps

interface dmem_if;

	logic                 en;     // read enable
	logic                 we;
	pipe_pkg::mem_idx_t   idx;    // word index
	rv_pkg::xlen_t        wdata;
	pipe_pkg::byte_mask_t wmask;
	rv_pkg::xlen_t        rdata;

	modport master (
		output en, we, idx, wdata, wmask,
		input  rdata
	);

	modport slave (
		input  en, we, idx, wdata, wmask,
		output rdata
	);

endinterface

/* hdl/pipe_pkg.sv */
`include "mem_defines.svh"

package pipe_pkg;

	typedef logic [`MEM_XLEN/8-1:0] byte_mask_t;  // one bit per lane
	typedef logic [`MEM_IDX_W-1:0]  mem_idx_t;

	typedef struct packed {
		rv_pkg::addr_t    pc;
		rv_pkg::inst_t    inst;
		rv_pkg::xlen_t    alu_result;  // address for loads and stores
		rv_pkg::xlen_t    rs2_data;
		rv_pkg::reg_idx_t rd;
		logic             reg_we;
		logic             mem_we;
		logic             wb_sel;      // 1 selects memory data
	} ex_mem_t;

	typedef struct packed {
		rv_pkg::addr_t    pc;
		rv_pkg::inst_t    inst;
		rv_pkg::reg_idx_t rd;
		logic             reg_we;
		rv_pkg::xlen_t    wb_data;
	} mem_wb_t;

	typedef struct packed {
		rv_pkg::reg_idx_t rd;
		logic             reg_we;
		rv_pkg::xlen_t    wb_data;
	} fwd_t;

endpackage

/* hdl/rv_pkg.sv */
`include "mem_defines.svh"

package rv_pkg;

	typedef logic [`MEM_XLEN-1:0] xlen_t;
	typedef logic [`MEM_XLEN-1:0] addr_t;  // byte address
	typedef logic [31:0]          inst_t;
	typedef logic [4:0]           reg_idx_t;
	typedef logic [2:0]           funct3_t;

	typedef enum logic [6:0] {
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_IMM32  = 7'b0011011,
		OP_REG    = 7'b0110011,
		OP_REG32  = 7'b0111011,
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011
	} opcode_e;

	// load/store width and signedness
	localparam funct3_t F3_B  = 3'b000;
	localparam funct3_t F3_H  = 3'b001;
	localparam funct3_t F3_W  = 3'b010;
	localparam funct3_t F3_D  = 3'b011;
	localparam funct3_t F3_BU = 3'b100;
	localparam funct3_t F3_HU = 3'b101;
	localparam funct3_t F3_WU = 3'b110;

endpackage

/* hdl/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data path width
`define MEM_XLEN 64

// first byte address of data memory
`define MEM_BASE 64'h0000_0000_8000_0000

// words in data memory
`define MEM_DEPTH 256

// log2 of MEM_DEPTH
`define MEM_IDX_W 8

`endif
